/* source/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// fetch ring geometry
//////////////////////////////////////////////////////////////////////

// bytes held by one instruction line
`define FETCH_LINE_BYTES 16

// line slots that make up the 64-byte ring
`define FETCH_NUM_LINES 4

// byte pointer into the ring with the slot index on top
`define FETCH_BIP_W 6

// decode length of 1 to 16 bytes
`define FETCH_LEN_W 5

`endif

/* source/fetch_buf_pkg.sv */
`include "fetch_macros.svh"

package fetch_buf_pkg;

    //////////////////////////////////////////////////////////////////////
    // buffer storage types
    //////////////////////////////////////////////////////////////////////

    // one line or one packet with byte k at bits 8k+7:8k
    typedef logic [`FETCH_LINE_BYTES*8-1:0] line_t;

    // slot number inside the ring
    typedef logic [$clog2(`FETCH_NUM_LINES)-1:0] line_idx_t;

    // ring byte pointer
    // upper bits pick the slot, lower four the byte in the line
    typedef logic [`FETCH_BIP_W-1:0] bip_t;

endpackage

/* source/fetch_ctrl_pkg.sv */
`include "fetch_macros.svh"

package fetch_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // control flow types
    //////////////////////////////////////////////////////////////////////

    // bytes consumed by decode for one instruction
    typedef logic [`FETCH_LEN_W-1:0] insn_len_t;

    // who loads the BIP this cycle in rising priority
    typedef enum logic [1:0] {
        src_none,
        src_branch,
        src_resteer,
        src_init
    } redirect_src_e;

endpackage

/* source/line_buffer.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module line_buffer
    import fetch_buf_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,

    // line fill from outside
    input  logic                              line_wr_en,
    input  line_idx_t                         line_wr_idx,
    input  line_t                             line_wr_data,

    // slot release from the aligner
    input  logic                              release_en,
    input  line_idx_t                         release_idx,

    output line_t [`FETCH_NUM_LINES-1:0]      line_data,
    output logic  [`FETCH_NUM_LINES-1:0]      line_valid,
    output logic  [`FETCH_NUM_LINES-1:0]      line_free
);

    line_t [`FETCH_NUM_LINES-1:0] line_q;
    logic  [`FETCH_NUM_LINES-1:0] valid_q;

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_wr_en) begin
            line_q[line_wr_idx] <= line_wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////

    // write beats release on the same slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < `FETCH_NUM_LINES; i++) begin
                if (line_wr_en && (line_wr_idx == line_idx_t'(i))) begin
                    valid_q[i] <= 1'b1;
                end else if (release_en && (release_idx == line_idx_t'(i))) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    assign line_data  = line_q;
    assign line_valid = valid_q;
    assign line_free  = ~valid_q;

    // fill side must only use slots shown free
    assert property (@(posedge clk) disable iff (!arst_n)
        line_wr_en |-> !valid_q[line_wr_idx])
    else $error("line write into valid slot %0d", line_wr_idx);

    // aligner may only free a slot it was reading from
    assert property (@(posedge clk) disable iff (!arst_n)
        release_en |-> valid_q[release_idx])
    else $error("release of empty slot %0d", release_idx);

endmodule

/* source/fetch_align.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_align
    import fetch_buf_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,

    // lines from the buffer
    input  line_t [`FETCH_NUM_LINES-1:0]      line_data,
    input  logic  [`FETCH_NUM_LINES-1:0]      line_valid,

    // redirects
    input  logic                              init_en,
    input  bip_t                              init_bip,
    input  logic                              resteer_en,
    input  bip_t                              resteer_bip,
    input  logic                              branch_en,
    input  bip_t                              branch_bip,

    // consumed length from the output stage
    input  logic                              adv_en,
    input  insn_len_t                         adv_len,

    output logic                              align_valid,
    output line_t                             align_packet,
    output bip_t                              align_bip,
    output logic                              release_en,
    output line_idx_t                         release_idx,
    output logic                              flush
);

    localparam int RING_BYTES = `FETCH_NUM_LINES * `FETCH_LINE_BYTES;
    localparam int RING_BITS  = RING_BYTES * 8;

    redirect_src_e redir_src;
    bip_t          redir_bip;
    logic          redirect;

    bip_t          bip_q;
    bip_t          adv_sum;
    line_idx_t     cur_slot;
    line_idx_t     next_slot;

    logic [RING_BITS-1:0] rot_stage [0:`FETCH_BIP_W];

    //////////////////////////////////////////////////////////////////////
    // redirect select
    //////////////////////////////////////////////////////////////////////

    // init over resteer over branch
    always_comb begin
        redir_src = src_none;
        redir_bip = bip_q;
        if (init_en) begin
            redir_src = src_init;
            redir_bip = init_bip;
        end else if (resteer_en) begin
            redir_src = src_resteer;
            redir_bip = resteer_bip;
        end else if (branch_en) begin
            redir_src = src_branch;
            redir_bip = branch_bip;
        end
    end

    assign redirect = (redir_src != src_none);
    assign flush    = redirect;

    //////////////////////////////////////////////////////////////////////
    // BIP register
    //////////////////////////////////////////////////////////////////////

    // wraps modulo ring size
    assign adv_sum   = bip_q + bip_t'(adv_len);
    assign cur_slot  = line_idx_t'(bip_q[`FETCH_BIP_W-1:`FETCH_BIP_W-2]);
    assign next_slot = cur_slot + line_idx_t'(1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bip_q <= '0;
        end else if (redirect) begin
            bip_q <= redir_bip;
        end else if (adv_en) begin
            bip_q <= adv_sum;
        end
    end

    // leaving a slot frees it at the same edge
    assign release_en  = adv_en && !redirect &&
                         (adv_sum[`FETCH_BIP_W-1:`FETCH_BIP_W-2] != cur_slot);
    assign release_idx = cur_slot;

    //////////////////////////////////////////////////////////////////////
    // ring rotator
    //////////////////////////////////////////////////////////////////////

    // log shifter where stage s moves the ring down by 2^s bytes
    assign rot_stage[0] = line_data;

    for (genvar s = 0; s < `FETCH_BIP_W; s++) begin : g_rot
        localparam int SH = 8 * (1 << s);
        assign rot_stage[s+1] = bip_q[s] ?
            {rot_stage[s][SH-1:0], rot_stage[s][RING_BITS-1:SH]} :
            rot_stage[s];
    end

    assign align_packet = rot_stage[`FETCH_BIP_W][`FETCH_LINE_BYTES*8-1:0];
    assign align_bip    = bip_q;

    // packet may straddle into the next slot, so both must be there
    assign align_valid = line_valid[cur_slot] && line_valid[next_slot] && !redirect;

    // decode never reports a zero or oversize length
    assert property (@(posedge clk) disable iff (!arst_n)
        adv_en |-> (adv_len >= 1) && (adv_len <= `FETCH_LINE_BYTES))
    else $error("advance length %0d out of range", adv_len);

endmodule

/* source/packet_out_stage.sv */
`timescale 1ns/1ps

module packet_out_stage
    import fetch_buf_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // from the aligner
    input  logic      align_valid,
    input  line_t     align_packet,
    input  bip_t      align_bip,
    input  logic      flush,

    // decode side
    input  logic      out_ready,
    input  insn_len_t insn_len,
    output logic      out_valid,
    output line_t     out_packet,
    output bip_t      out_bip,

    // advance back to the aligner
    output logic      adv_en,
    output insn_len_t adv_len
);

    logic load;
    logic handshake;

    assign handshake = out_valid && out_ready;
    assign load      = !out_valid && align_valid && !flush;

    //////////////////////////////////////////////////////////////////////
    // one-entry packet register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush || handshake) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_packet <= align_packet;
            out_bip    <= align_bip;
        end
    end

    // decode length goes straight back as the advance
    assign adv_en  = handshake;
    assign adv_len = insn_len;

    // stalled packet stays put unless a redirect drops it
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready && !flush |=>
            out_valid && $stable(out_packet) && $stable(out_bip))
    else $error("packet changed under stall");

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top
    import fetch_buf_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,

    // line fill
    input  logic                         line_wr_en,
    input  line_idx_t                    line_wr_idx,
    input  line_t                        line_wr_data,
    output logic [`FETCH_NUM_LINES-1:0]  line_free,

    // redirects
    input  logic                         init_en,
    input  bip_t                         init_bip,
    input  logic                         resteer_en,
    input  bip_t                         resteer_bip,
    input  logic                         branch_en,
    input  bip_t                         branch_bip,

    // decode
    output logic                         out_valid,
    output line_t                        out_packet,
    output bip_t                         out_bip,
    input  logic                         out_ready,
    input  insn_len_t                    insn_len
);

    line_t [`FETCH_NUM_LINES-1:0] line_data;
    logic  [`FETCH_NUM_LINES-1:0] line_valid;
    logic                         release_en;
    line_idx_t                    release_idx;
    logic                         align_valid;
    line_t                        align_packet;
    bip_t                         align_bip;
    logic                         flush;
    logic                         adv_en;
    insn_len_t                    adv_len;

    line_buffer i_line_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .line_wr_en   (line_wr_en),
        .line_wr_idx  (line_wr_idx),
        .line_wr_data (line_wr_data),
        .release_en   (release_en),
        .release_idx  (release_idx),
        .line_data    (line_data),
        .line_valid   (line_valid),
        .line_free    (line_free)
    );

    fetch_align i_fetch_align (
        .clk          (clk),
        .arst_n       (arst_n),
        .line_data    (line_data),
        .line_valid   (line_valid),
        .init_en      (init_en),
        .init_bip     (init_bip),
        .resteer_en   (resteer_en),
        .resteer_bip  (resteer_bip),
        .branch_en    (branch_en),
        .branch_bip   (branch_bip),
        .adv_en       (adv_en),
        .adv_len      (adv_len),
        .align_valid  (align_valid),
        .align_packet (align_packet),
        .align_bip    (align_bip),
        .release_en   (release_en),
        .release_idx  (release_idx),
        .flush        (flush)
    );

    packet_out_stage i_packet_out_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .align_valid  (align_valid),
        .align_packet (align_packet),
        .align_bip    (align_bip),
        .flush        (flush),
        .out_ready    (out_ready),
        .insn_len     (insn_len),
        .out_valid    (out_valid),
        .out_packet   (out_packet),
        .out_bip      (out_bip),
        .adv_en       (adv_en),
        .adv_len      (adv_len)
    );

endmodule

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;

    localparam int LINE_BITS  = `FETCH_LINE_BYTES * 8;
    localparam int RING_BYTES = `FETCH_NUM_LINES * `FETCH_LINE_BYTES;

    logic                         clk;
    logic                         arst_n;
    logic                         line_wr_en;
    logic [1:0]                   line_wr_idx;
    logic [LINE_BITS-1:0]         line_wr_data;
    logic [`FETCH_NUM_LINES-1:0]  line_free;
    logic                         init_en;
    logic [`FETCH_BIP_W-1:0]      init_bip;
    logic                         resteer_en;
    logic [`FETCH_BIP_W-1:0]      resteer_bip;
    logic                         branch_en;
    logic [`FETCH_BIP_W-1:0]      branch_bip;
    logic                         out_valid;
    logic [LINE_BITS-1:0]         out_packet;
    logic [`FETCH_BIP_W-1:0]      out_bip;
    logic                         out_ready;
    logic [`FETCH_LEN_W-1:0]      insn_len;

    // records from the data file
    logic [7:0]           rec_kind [$];
    logic [LINE_BITS-1:0] rec_a [$];
    logic [LINE_BITS-1:0] rec_b [$];
    logic [LINE_BITS-1:0] rec_c [$];
    logic [LINE_BITS-1:0] rec_d [$];

    // ring model
    logic [7:0]                  ring [0:RING_BYTES-1];
    logic [`FETCH_BIP_W-1:0]     model_bip;
    logic [`FETCH_NUM_LINES-1:0] model_valid;
    logic                        exp_pending;
    logic [`FETCH_BIP_W-1:0]     exp_bip;
    logic [LINE_BITS-1:0]        exp_packet;

    int cycle_count = 0;
    int cycle_limit = 100;

    fetch_top i_fetch_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .line_wr_en   (line_wr_en),
        .line_wr_idx  (line_wr_idx),
        .line_wr_data (line_wr_data),
        .line_free    (line_free),
        .init_en      (init_en),
        .init_bip     (init_bip),
        .resteer_en   (resteer_en),
        .resteer_bip  (resteer_bip),
        .branch_en    (branch_en),
        .branch_bip   (branch_bip),
        .out_valid    (out_valid),
        .out_packet   (out_packet),
        .out_bip      (out_bip),
        .out_ready    (out_ready),
        .insn_len     (insn_len)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run("timeout, the DUT stopped producing packets");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [LINE_BITS-1:0] actual,
                               input logic [LINE_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            fail_run("first mismatch ends the run");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // ring model
    //////////////////////////////////////////////////////////////////////

    // packet byte k is ring byte bip+k modulo 64
    function automatic logic [LINE_BITS-1:0] model_packet();
        logic [LINE_BITS-1:0]    pkt;
        logic [`FETCH_BIP_W-1:0] n;
        pkt = '0;
        for (int k = 0; k < `FETCH_LINE_BYTES; k++) begin
            n = model_bip + k[5:0];
            pkt[8*k +: 8] = ring[n];
        end
        return pkt;
    endfunction

    function automatic logic model_avail();
        logic [1:0] slot;
        slot = model_bip[5:4];
        return model_valid[slot] && model_valid[slot + 2'd1];
    endfunction

    // slots the model holds no line for
    function automatic logic [`FETCH_NUM_LINES-1:0] model_free();
        return ~model_valid;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // record actions that start and end at a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic write_line(input logic [1:0] idx, input logic [LINE_BITS-1:0] data);
        if (model_valid[idx]) begin
            fail_run("data file writes a slot that still holds a line");
        end
        check_value("line_free", LINE_BITS'(line_free[idx]), LINE_BITS'(1));
        line_wr_en   = 1'b1;
        line_wr_idx  = idx;
        line_wr_data = data;
        @(posedge clk);
        @(negedge clk);
        line_wr_en   = 1'b0;
        for (int k = 0; k < `FETCH_LINE_BYTES; k++) begin
            ring[{idx, k[3:0]}] = data[8*k +: 8];
        end
        model_valid[idx] = 1'b1;
        check_value("line_free", LINE_BITS'(line_free), LINE_BITS'(model_free()));
    endtask

    task automatic redirect_bip(input logic [2:0] sources, input logic [5:0] i_target,
                                input logic [5:0] r_target, input logic [5:0] b_target);
        init_en     = sources[2];
        init_bip    = i_target;
        resteer_en  = sources[1];
        resteer_bip = r_target;
        branch_en   = sources[0];
        branch_bip  = b_target;
        @(posedge clk);
        @(negedge clk);
        init_en    = 1'b0;
        resteer_en = 1'b0;
        branch_en  = 1'b0;
        if (sources[2]) begin
            model_bip = i_target;
        end else if (sources[1]) begin
            model_bip = r_target;
        end else if (sources[0]) begin
            model_bip = b_target;
        end
        // held packet must be gone
        check_value("out_valid", LINE_BITS'(out_valid), LINE_BITS'(0));
    endtask

    task automatic accept_packet(input logic [4:0] len);
        logic [LINE_BITS-1:0]    want_packet;
        logic [`FETCH_BIP_W-1:0] want_bip;
        logic [1:0]              old_slot;
        while (!out_valid) begin
            @(posedge clk);
            @(negedge clk);
        end
        want_bip    = model_bip;
        want_packet = model_packet();
        if (exp_pending) begin
            // file values must agree with the ring model
            check_value("file bip", LINE_BITS'(exp_bip), LINE_BITS'(want_bip));
            check_value("file packet", exp_packet, want_packet);
            want_bip    = exp_bip;
            want_packet = exp_packet;
            exp_pending = 1'b0;
        end
        check_value("out_bip", LINE_BITS'(out_bip), LINE_BITS'(want_bip));
        check_value("out_packet", out_packet, want_packet);
        out_ready = 1'b1;
        insn_len  = len;
        @(posedge clk);
        @(negedge clk);
        out_ready = 1'b0;
        insn_len  = '0;
        old_slot  = model_bip[5:4];
        model_bip = model_bip + {1'b0, len};
        if (model_bip[5:4] != old_slot) begin
            model_valid[old_slot] = 1'b0;
        end
        check_value("line_free", LINE_BITS'(line_free), LINE_BITS'(model_free()));
    endtask

    task automatic stall_cycles(input int n);
        logic                    held;
        logic [LINE_BITS-1:0]    held_packet;
        logic [`FETCH_BIP_W-1:0] held_bip;
        held        = 1'b0;
        held_packet = '0;
        held_bip    = '0;
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            if (!model_avail()) begin
                check_value("out_valid", LINE_BITS'(out_valid), LINE_BITS'(0));
            end
            if (held) begin
                check_value("out_valid", LINE_BITS'(out_valid), LINE_BITS'(1));
                check_value("out_packet", out_packet, held_packet);
                check_value("out_bip", LINE_BITS'(out_bip), LINE_BITS'(held_bip));
                check_value("out_bip", LINE_BITS'(out_bip), LINE_BITS'(model_bip));
            end else if (out_valid) begin
                held        = 1'b1;
                held_packet = out_packet;
                held_bip    = out_bip;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int                   fd;
        int                   code;
        int                   want;
        int                   n;
        logic [7:0]           tag;
        logic [8*160-1:0]     skip;
        logic [LINE_BITS-1:0] a;
        logic [LINE_BITS-1:0] b;
        logic [LINE_BITS-1:0] c;
        logic [LINE_BITS-1:0] d;

        arst_n       = 1'b0;
        line_wr_en   = 1'b0;
        line_wr_idx  = '0;
        line_wr_data = '0;
        init_en      = 1'b0;
        init_bip     = '0;
        resteer_en   = 1'b0;
        resteer_bip  = '0;
        branch_en    = 1'b0;
        branch_bip   = '0;
        out_ready    = 1'b0;
        insn_len     = '0;
        model_bip    = '0;
        model_valid  = '0;
        exp_pending  = 1'b0;
        exp_bip      = '0;
        exp_packet   = '0;
        for (int i = 0; i < RING_BYTES; i++) begin
            ring[i] = 8'h00;
        end

        fd = $fopen("tests/fetch_tests.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/fetch_tests.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tag);
            if (code != 1) begin
                break;
            end
            a    = '0;
            b    = '0;
            c    = '0;
            d    = '0;
            n    = 0;
            want = 0;
            case (tag)
                "#": code = $fgets(skip, fd);
                "W": begin
                    want = 2;
                    code = $fscanf(fd, "%h %h", a, b);
                end
                "R": begin
                    want = 4;
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                end
                "A": begin
                    want = 1;
                    code = $fscanf(fd, "%h", a);
                end
                "S": begin
                    want = 1;
                    code = $fscanf(fd, "%d", n);
                    a[31:0] = n;
                end
                "E": begin
                    want = 2;
                    code = $fscanf(fd, "%h %h", a, b);
                end
                default: fail_run("unknown record kind in tests/fetch_tests.txt");
            endcase
            if (want != 0) begin
                if (code != want) begin
                    fail_run("malformed record in tests/fetch_tests.txt");
                end
                rec_kind.push_back(tag);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
                rec_d.push_back(d);
            end
        end
        $fclose(fd);
        cycle_limit = 20 * rec_kind.size() + 100;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_value("out_valid", LINE_BITS'(out_valid), LINE_BITS'(0));
        check_value("line_free", LINE_BITS'(line_free), LINE_BITS'(4'hf));

        foreach (rec_kind[i]) begin
            case (rec_kind[i])
                "W": write_line(rec_a[i][1:0], rec_b[i]);
                "R": redirect_bip(rec_a[i][2:0], rec_b[i][5:0], rec_c[i][5:0], rec_d[i][5:0]);
                "A": accept_packet(rec_a[i][4:0]);
                "S": stall_cycles(rec_a[i][31:0]);
                "E": begin
                    exp_pending = 1'b1;
                    exp_bip     = rec_a[i][5:0];
                    exp_packet  = rec_b[i];
                end
                default: fail_run("bad record kind in stored records");
            endcase
        end

        if (exp_pending) begin
            fail_run("expected packet at the end of the file was never handed out");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+source
source/fetch_buf_pkg.sv
source/fetch_ctrl_pkg.sv
source/line_buffer.sv
source/fetch_align.sv
source/packet_out_stage.sv
source/fetch_top.sv
tests/fetch_tb.sv

/* run.sh */
#!/bin/sh
# builds the fetch aligner testbench with Verilator and runs it
# a failing check ends the simulation with $fatal, which gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module fetch_tb \
    -o fetch_sim

./obj_dir/fetch_sim

/* tests/fetch_tests.txt */
# columns: W slot data | R mask(4=init 2=resteer 1=branch) init resteer branch
# A length | S cycles | E bip packet   (all hex except S, packet byte 0 rightmost)
# only slot 0 present, no packet may come out
W 0 0f0e0d0c0b0a09080706050403020100
S 4
# second slot makes the packet at BIP 0
W 1 1f1e1d1c1b1a19181716151413121110
E 00 0f0e0d0c0b0a09080706050403020100
A 5
# packet now straddles slot 0 and slot 1
E 05 14131211100f0e0d0c0b0a0908070605
# held under stall
S 3
A 6
# crossing into slot 1 frees slot 0
A 7
S 3
W 2 2f2e2d2c2b2a29282726252423222120
E 12 21201f1e1d1c1b1a1918171615141312
A 10
W 3 3f3e3d3c3b3a39383736353433323130
A 10
# refill slot 0 so the ring can wrap from slot 3
W 0 4f4e4d4c4b4a49484746454443424140
E 32 41403f3e3d3c3b3a3938373635343332
A f
# pointer wrapped to 01, slot 1 still empty
S 2
W 1 1f1e1d1c1b1a19181716151413121110
A 2
W 2 2f2e2d2c2b2a29282726252423222120
W 3 3f3e3d3c3b3a39383736353433323130
# packet at 03 held while the redirect arrives
S 2
# init and branch together, init wins
R 5 28 00 10
E 28 37363534333231302f2e2d2c2b2a2928
A 3
S 2
# resteer and branch together, resteer wins
R 3 00 3c 04
E 3c 4b4a494847464544434241403f3e3d3c
A 4
# branch alone
R 1 00 00 07
A 9
E 10 1f1e1d1c1b1a19181716151413121110
S 3
A 1
S 2
